// File: core_mem_region.sv
`default_nettype none

module core_mem_region (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Core LSU port
  input  logic                                 lsu_req_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    lsu_addr_i,
  input  logic                                 lsu_we_i,
  input  logic [mem_region_pkg::BE_W-1:0]      lsu_be_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    lsu_wdata_i,
  output logic                                 lsu_gnt_o,
  output logic                                 lsu_rvalid_o,
  output logic [mem_region_pkg::WORD_W-1:0]    lsu_rdata_o,

  // Host loader port, addressed by word index
  input  logic                                 host_req_i,
  input  logic                                 host_we_i,
  input  logic [mem_region_pkg::BE_W-1:0]      host_be_i,
  input  logic [mem_region_pkg::RAM_IDX_W-1:0] host_addr_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    host_wdata_i,
  output logic [mem_region_pkg::WORD_W-1:0]    host_rdata_o,

  // External bus port
  output logic                                 ext_req_o,
  output logic [mem_region_pkg::WORD_W-1:0]    ext_addr_o,
  output logic                                 ext_we_o,
  output logic [mem_region_pkg::BE_W-1:0]      ext_be_o,
  output logic [mem_region_pkg::WORD_W-1:0]    ext_wdata_o,
  input  logic                                 ext_gnt_i,
  input  logic                                 ext_rvalid_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    ext_rdata_i
);

  // Core side of the RAM mux
  logic                                 ram_req;
  logic                                 ram_gnt;
  logic                                 ram_rvalid;
  logic [mem_region_pkg::RAM_IDX_W-1:0] ram_core_idx;

  // Physical RAM port
  logic                                 mem_en;
  logic                                 mem_we;
  logic [mem_region_pkg::BE_W-1:0]      mem_be;
  logic [mem_region_pkg::RAM_IDX_W-1:0] mem_idx;
  logic [mem_region_pkg::WORD_W-1:0]    mem_wdata;
  logic [mem_region_pkg::WORD_W-1:0]    mem_rdata;

  mem_region_decoder u_decoder (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ram_req_o    ( ram_req      ),
    .ram_idx_o    ( ram_core_idx ),
    .ram_gnt_i    ( ram_gnt      ),
    .ram_rvalid_i ( ram_rvalid   ),
    .ram_rdata_i  ( mem_rdata    ),
    .ext_req_o    ( ext_req_o    ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

  // Write controls go straight out, the decoder only steers req and gnt
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  ram_port_mux u_ram_mux (
    .clk           ( clk          ),
    .rst_n         ( rst_n        ),
    .host_req_i    ( host_req_i   ),
    .host_we_i     ( host_we_i    ),
    .host_be_i     ( host_be_i    ),
    .host_idx_i    ( host_addr_i  ),
    .host_wdata_i  ( host_wdata_i ),
    .core_req_i    ( ram_req      ),
    .core_we_i     ( lsu_we_i     ),
    .core_be_i     ( lsu_be_i     ),
    .core_idx_i    ( ram_core_idx ),
    .core_wdata_i  ( lsu_wdata_i  ),
    .core_gnt_o    ( ram_gnt      ),
    .core_rvalid_o ( ram_rvalid   ),
    .ram_en_o      ( mem_en       ),
    .ram_we_o      ( mem_we       ),
    .ram_be_o      ( mem_be       ),
    .ram_idx_o     ( mem_idx      ),
    .ram_wdata_o   ( mem_wdata    )
  );

  sp_data_ram u_data_ram (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .we_i    ( mem_we    ),
    .be_i    ( mem_be    ),
    .idx_i   ( mem_idx   ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  // Host sees the shared read register
  assign host_rdata_o = mem_rdata;

endmodule

`default_nettype wire

// File: core_mem_region_sva.sv
`default_nettype none

module core_mem_region_sva (
  input  logic clk,
  input  logic rst_n,
  input  logic lsu_req_i,
  input  logic lsu_gnt_i,
  input  logic lsu_rvalid_i,
  input  logic ram_req_i,
  input  logic ram_gnt_i,
  input  logic ext_req_i
);

  // Decoder sends a request to one side only
  property one_target_p;
    @(posedge clk) disable iff (!rst_n)
      !(ram_req_i && ext_req_i);
  endproperty

  // No grant without a request
  property gnt_needs_req_p;
    @(posedge clk) disable iff (!rst_n)
      lsu_gnt_i |-> lsu_req_i;
  endproperty

  // RAM responds in the cycle after the grant
  property ram_rvalid_next_p;
    @(posedge clk) disable iff (!rst_n)
      ram_gnt_i |=> lsu_rvalid_i;
  endproperty

  one_target_a : assert property (one_target_p)
    else $error("RAM and external requests high together");

  gnt_needs_req_a : assert property (gnt_needs_req_p)
    else $error("lsu_gnt_o high without lsu_req_i");

  ram_rvalid_next_a : assert property (ram_rvalid_next_p)
    else $error("lsu_rvalid_o missing one cycle after a RAM grant");

endmodule

bind core_mem_region core_mem_region_sva u_sva (
  .clk          ( clk          ),
  .rst_n        ( rst_n        ),
  .lsu_req_i    ( lsu_req_i    ),
  .lsu_gnt_i    ( lsu_gnt_o    ),
  .lsu_rvalid_i ( lsu_rvalid_o ),
  .ram_req_i    ( ram_req      ),
  .ram_gnt_i    ( ram_gnt      ),
  .ext_req_i    ( ext_req_o    )
);

`default_nettype wire

// File: mem_region_decoder.sv
`default_nettype none

module mem_region_decoder (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // LSU request side
  input  logic                                 lsu_req_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    lsu_addr_i,
  output logic                                 lsu_gnt_o,
  output logic                                 lsu_rvalid_o,
  output logic [mem_region_pkg::WORD_W-1:0]    lsu_rdata_o,

  // Toward the RAM port mux
  output logic                                 ram_req_o,
  output logic [mem_region_pkg::RAM_IDX_W-1:0] ram_idx_o,
  input  logic                                 ram_gnt_i,
  input  logic                                 ram_rvalid_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    ram_rdata_i,

  // Toward the external port
  output logic                                 ext_req_o,
  input  logic                                 ext_gnt_i,
  input  logic                                 ext_rvalid_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    ext_rdata_i
);

  mem_region_pkg::lsu_addr_u lsu_addr;

  logic is_ram_addr;

  // Set while the pending response belongs to the external port
  logic resp_ext_q;

  assign lsu_addr.raw = lsu_addr_i;

  // Only one region maps onto the local RAM, all else goes outside
  assign is_ram_addr = (lsu_addr.fields.region == mem_region_pkg::RAM_REGION);

  assign ram_req_o = lsu_req_i & is_ram_addr;
  assign ext_req_o = lsu_req_i & ~is_ram_addr;

  // Word index, byte offset is dropped
  assign ram_idx_o = lsu_addr.fields.idx;

  // Grant comes from whichever side the request went to
  always_comb
  begin
    lsu_gnt_o = 1'b0;

    if (ext_req_o)
    begin
      lsu_gnt_o = ext_gnt_i;
    end
    else if (ram_req_o)
    begin
      lsu_gnt_o = ram_gnt_i;
    end
  end

  // Remember the response source on every accepted access
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      resp_ext_q <= 1'b0;
    end
    else if (lsu_gnt_o)
    begin
      resp_ext_q <= ext_req_o;
    end
  end

  // Route response back to the LSU
  assign lsu_rdata_o = resp_ext_q ? ext_rdata_i : ram_rdata_i;

  // At most one access is pending, so the two valids never overlap
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;

endmodule

`default_nettype wire

// File: mem_region_pkg.sv
`default_nettype none

package mem_region_pkg;

  // Data word and byte lanes
  localparam int WORD_W   = 32;
  localparam int BE_W     = 4;
  localparam int OFFSET_W = 2;

  // Local data RAM geometry
  localparam int RAM_IDX_W = 10;
  localparam int RAM_WORDS = 1024;

  // Region field at the top of the address
  localparam int REGION_W = 12;
  localparam logic [REGION_W-1:0] RAM_REGION = 12'h001;

  // Bits between the region field and the RAM word index
  localparam int GAP_W = WORD_W - REGION_W - RAM_IDX_W - OFFSET_W;

  // LSU address, either as the raw bus word or split into fields
  typedef union packed {
    logic [WORD_W-1:0] raw;
    struct packed {
      logic [REGION_W-1:0]  region;
      logic [GAP_W-1:0]     unused;
      logic [RAM_IDX_W-1:0] idx;
      logic [OFFSET_W-1:0]  offset;
    } fields;
  } lsu_addr_u;

endpackage

`default_nettype wire

// File: ram_port_mux.sv
`default_nettype none

module ram_port_mux (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Host loader port, always accepted
  input  logic                                 host_req_i,
  input  logic                                 host_we_i,
  input  logic [mem_region_pkg::BE_W-1:0]      host_be_i,
  input  logic [mem_region_pkg::RAM_IDX_W-1:0] host_idx_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    host_wdata_i,

  // Core data port
  input  logic                                 core_req_i,
  input  logic                                 core_we_i,
  input  logic [mem_region_pkg::BE_W-1:0]      core_be_i,
  input  logic [mem_region_pkg::RAM_IDX_W-1:0] core_idx_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    core_wdata_i,
  output logic                                 core_gnt_o,
  output logic                                 core_rvalid_o,

  // Single RAM port
  output logic                                 ram_en_o,
  output logic                                 ram_we_o,
  output logic [mem_region_pkg::BE_W-1:0]      ram_be_o,
  output logic [mem_region_pkg::RAM_IDX_W-1:0] ram_idx_o,
  output logic [mem_region_pkg::WORD_W-1:0]    ram_wdata_o
);

  logic core_rvalid_q;

  // Host wins, core only gets the idle cycles
  assign core_gnt_o = core_req_i & ~host_req_i;

  assign ram_en_o = host_req_i | core_gnt_o;

  // Steer the winner onto the RAM port
  always_comb
  begin
    if (host_req_i)
    begin
      ram_we_o    = host_we_i;
      ram_be_o    = host_be_i;
      ram_idx_o   = host_idx_i;
      ram_wdata_o = host_wdata_i;
    end
    else
    begin
      ram_we_o    = core_we_i;
      ram_be_o    = core_be_i;
      ram_idx_o   = core_idx_i;
      ram_wdata_o = core_wdata_i;
    end
  end

  // RAM answers one cycle after the access, writes included
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      core_rvalid_q <= 1'b0;
    end
    else
    begin
      core_rvalid_q <= core_gnt_o;
    end
  end

  assign core_rvalid_o = core_rvalid_q;

endmodule

`default_nettype wire

// File: sp_data_ram.sv
`default_nettype none

module sp_data_ram (
  input  logic                                 clk,
  input  logic                                 en_i,
  input  logic                                 we_i,
  input  logic [mem_region_pkg::BE_W-1:0]      be_i,
  input  logic [mem_region_pkg::RAM_IDX_W-1:0] idx_i,
  input  logic [mem_region_pkg::WORD_W-1:0]    wdata_i,
  output logic [mem_region_pkg::WORD_W-1:0]    rdata_o
);

  logic [mem_region_pkg::WORD_W-1:0] mem [mem_region_pkg::RAM_WORDS];

  logic [mem_region_pkg::WORD_W-1:0] rdata_q;

  // Byte-masked write
  always_ff @(posedge clk)
  begin
    if (en_i && we_i)
    begin
      for (int b = 0; b < mem_region_pkg::BE_W; b++)
      begin
        if (be_i[b])
        begin
          mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data register, kept until the next read
  always_ff @(posedge clk)
  begin
    if (en_i && !we_i)
    begin
      rdata_q <= mem[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: tb_core_mem_region.sv
`default_nettype none

module tb_core_mem_region;

  localparam int N_RAM_RD = 32;
  localparam int N_PART   = 40;
  localparam int N_EXT    = 40;
  localparam int N_BLOCK  = 12;
  localparam int N_ALT    = 16;
  // Host preload counts one transaction per word
  localparam int N_TRANS  = mem_region_pkg::RAM_WORDS + N_RAM_RD + 3 * N_PART + N_EXT
                            + 2 * N_BLOCK + 2 * N_ALT;
  localparam int TIMEOUT_CYCLES = 20 * N_TRANS + 200;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 lsu_req_i;
  logic [mem_region_pkg::WORD_W-1:0]    lsu_addr_i;
  logic                                 lsu_we_i;
  logic [mem_region_pkg::BE_W-1:0]      lsu_be_i;
  logic [mem_region_pkg::WORD_W-1:0]    lsu_wdata_i;
  logic                                 lsu_gnt_o;
  logic                                 lsu_rvalid_o;
  logic [mem_region_pkg::WORD_W-1:0]    lsu_rdata_o;
  logic                                 host_req_i;
  logic                                 host_we_i;
  logic [mem_region_pkg::BE_W-1:0]      host_be_i;
  logic [mem_region_pkg::RAM_IDX_W-1:0] host_addr_i;
  logic [mem_region_pkg::WORD_W-1:0]    host_wdata_i;
  logic [mem_region_pkg::WORD_W-1:0]    host_rdata_o;
  logic                                 ext_req_o;
  logic [mem_region_pkg::WORD_W-1:0]    ext_addr_o;
  logic                                 ext_we_o;
  logic [mem_region_pkg::BE_W-1:0]      ext_be_o;
  logic [mem_region_pkg::WORD_W-1:0]    ext_wdata_o;
  logic                                 ext_gnt_i;
  logic                                 ext_rvalid_i;
  logic [mem_region_pkg::WORD_W-1:0]    ext_rdata_i;

  integer seed   = 32'h7b3c6968;
  int     errors = 0;
  int     checks = 0;
  int     cyc    = 0;

  // Expected contents of the local RAM and of the external slave
  logic [mem_region_pkg::WORD_W-1:0] shadow     [mem_region_pkg::RAM_WORDS];
  logic [mem_region_pkg::WORD_W-1:0] ext_shadow [mem_region_pkg::RAM_WORDS];
  logic [mem_region_pkg::WORD_W-1:0] ext_mem    [mem_region_pkg::RAM_WORDS];

  // Outstanding LSU responses and host reads
  logic                              exp_rd_q[$];
  logic [mem_region_pkg::WORD_W-1:0] exp_data_q[$];
  logic [mem_region_pkg::WORD_W-1:0] host_exp_q[$];

  core_mem_region UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    while (cyc < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  // Old word with the enabled bytes replaced
  function automatic logic [31:0] ref_merge(input logic [31:0] old_word,
                                            input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (wdata & mask);
  endfunction

  function automatic logic [31:0] ram_fill(input logic [9:0] idx);
    return {6'h2b, idx, 6'h14, idx};
  endfunction

  function automatic logic [31:0] ext_fill(input logic [9:0] idx);
    return {~idx, 12'h5e0, idx};
  endfunction

  function automatic logic [31:0] rand_ram_addr(input logic [9:0] idx);
    mem_region_pkg::lsu_addr_u a;
    a.fields.region = mem_region_pkg::RAM_REGION;
    a.fields.unused = $random(seed);
    a.fields.idx    = idx;
    a.fields.offset = $random(seed);
    return a.raw;
  endfunction

  function automatic logic [31:0] rand_ext_addr();
    mem_region_pkg::lsu_addr_u a;
    a.raw = $random(seed);
    if (a.fields.region == mem_region_pkg::RAM_REGION)
    begin
      a.fields.region = ~mem_region_pkg::RAM_REGION;
    end
    return a.raw;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
    end
  endtask

  // Drives a host strobe for this cycle and updates the shadow at once
  task automatic drive_host(input logic we, input logic [3:0] be, input logic [9:0] idx,
                            input logic [31:0] wdata);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_be_i    = be;
    host_addr_i  = idx;
    host_wdata_i = wdata;
    if (we)
      shadow[idx] = ref_merge(shadow[idx], wdata, be);
    else
      host_exp_q.push_back(shadow[idx]);
  endtask

  task automatic host_access(input logic we, input logic [3:0] be, input logic [9:0] idx,
                             input logic [31:0] wdata);
    drive_host(we, be, idx, wdata);
    @(posedge clk);
    #1;
    host_req_i = 1'b0;
  endtask

  // One LSU access that may collide with a host write in its first cycle
  task automatic lsu_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, input logic host_block);
    mem_region_pkg::lsu_addr_u a;
    logic                      is_ram;
    logic                      granted;
    logic                      first;
    logic [9:0]                hidx;
    a.raw       = addr;
    is_ram      = (a.fields.region == mem_region_pkg::RAM_REGION);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    if (host_block)
    begin
      hidx = ($random(seed) & 1) ? a.fields.idx : 10'($random(seed));
      drive_host(1'b1, 4'($random(seed)), hidx, $random(seed));
    end
    granted = 1'b0;
    first   = 1'b1;
    while (!granted)
    begin
      @(negedge clk);
      if (is_ram)
      begin
        // RAM grant in the request cycle unless the host strobe takes the port
        check_value("lsu_gnt_o", lsu_gnt_o, !(first && host_block));
        check_value("ext_req_o", ext_req_o, 1'b0);
      end
      else
      begin
        check_value("lsu_gnt_o", lsu_gnt_o, ext_gnt_i);
        check_value("ext_req_o", ext_req_o, 1'b1);
        check_value("ext_addr_o", ext_addr_o, addr);
        check_value("ext_we_o", ext_we_o, we);
        check_value("ext_be_o", ext_be_o, be);
        check_value("ext_wdata_o", ext_wdata_o, wdata);
      end
      granted = lsu_gnt_o;
      if (granted)
      begin
        if (we && is_ram)
          shadow[a.fields.idx] = ref_merge(shadow[a.fields.idx], wdata, be);
        else if (we)
          ext_shadow[a.fields.idx] = ref_merge(ext_shadow[a.fields.idx], wdata, be);
        exp_rd_q.push_back(!we);
        exp_data_q.push_back(is_ram ? shadow[a.fields.idx] : ext_shadow[a.fields.idx]);
      end
      @(posedge clk);
      #1;
      host_req_i = 1'b0;
      first      = 1'b0;
    end
    lsu_req_i = 1'b0;
    // Core waits for the response before the next request
    @(negedge clk);
    while (!lsu_rvalid_o)
      @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // External slave model that stalls its grant at random and answers two cycles later
  initial
  begin : ext_slave
    mem_region_pkg::lsu_addr_u acc;
    logic                      busy;
    int                        stall;
    int                        pend;
    logic [31:0]               pend_data;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    busy         = 1'b0;
    stall        = 0;
    pend         = 0;
    pend_data    = '0;
    for (int i = 0; i < mem_region_pkg::RAM_WORDS; i++)
      ext_mem[i] = ext_fill(10'(i));
    forever
    begin
      @(negedge clk);
      if (ext_req_o && ext_gnt_i)
      begin
        acc.raw = ext_addr_o;
        busy    = 1'b0;
        pend    = 2;
        for (int b = 0; b < mem_region_pkg::BE_W; b++)
          if (ext_we_o && ext_be_o[b])
            ext_mem[acc.fields.idx][b*8 +: 8] = ext_wdata_o[b*8 +: 8];
        pend_data = ext_mem[acc.fields.idx];
      end
      @(posedge clk);
      #2;
      ext_rvalid_i = 1'b0;
      if (pend > 0)
      begin
        pend--;
        ext_rvalid_i = (pend == 0);
        ext_rdata_i  = pend_data;
      end
      if (ext_req_o)
      begin
        if (!busy)
        begin
          stall = $unsigned($random(seed)) % 4;
          busy  = 1'b1;
        end
        else if (stall > 0)
        begin
          stall--;
        end
      end
      ext_gnt_i = ext_req_o && (stall == 0);
    end
  end

  // Response checker
  initial
  begin : response_check
    mem_region_pkg::lsu_addr_u a;
    logic                      host_chk;
    logic                      gnt_ram;
    int                        gnt_cyc;
    logic                      rd;
    logic [31:0]               exp;
    host_chk = 1'b0;
    gnt_ram  = 1'b0;
    gnt_cyc  = 0;
    forever
    begin
      @(negedge clk);
      if (lsu_rvalid_o)
      begin
        assert (exp_rd_q.size() > 0)
        else
        begin
          errors++;
          $display("Error at %0t: lsu_rvalid_o pulsed with no access outstanding", $time);
        end
        if (exp_rd_q.size() > 0)
        begin
          rd  = exp_rd_q.pop_front();
          exp = exp_data_q.pop_front();
          if (rd)
            check_value("lsu_rdata_o", lsu_rdata_o, exp);
          // Slave answers two cycles after its grant and rvalid passes straight through
          if (gnt_ram)
            check_value("lsu_rvalid_o latency", cyc - gnt_cyc, 1);
          else
            check_value("lsu_rvalid_o latency", cyc - gnt_cyc, 2);
        end
      end
      if (lsu_gnt_o)
      begin
        a.raw   = lsu_addr_i;
        gnt_ram = (a.fields.region == mem_region_pkg::RAM_REGION);
        gnt_cyc = cyc;
      end
      if (host_chk)
        check_value("host_rdata_o", host_rdata_o, host_exp_q.pop_front());
      host_chk = host_req_i && !host_we_i;
    end
  end

  initial
  begin : stimulus
    logic [9:0]  idx;
    logic [31:0] addr;
    logic [31:0] last_ext;
    logic        we;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    last_ext     = '0;
    for (int i = 0; i < mem_region_pkg::RAM_WORDS; i++)
      ext_shadow[i] = ext_fill(10'(i));
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle outputs and RAM response source after reset
    repeat (4)
    begin
      @(negedge clk);
      check_value("lsu_gnt_o", lsu_gnt_o, 1'b0);
      check_value("lsu_rvalid_o", lsu_rvalid_o, 1'b0);
      check_value("ext_req_o", ext_req_o, 1'b0);
      check_value("resp_ext_q", UUT.u_decoder.resp_ext_q, 1'b0);
    end
    @(posedge clk);
    #1;

    // Host preloads every word and the LSU reads back a sample
    for (int i = 0; i < mem_region_pkg::RAM_WORDS; i++)
      host_access(1'b1, 4'hf, 10'(i), ram_fill(10'(i)));
    for (int i = 0; i < N_RAM_RD; i++)
    begin
      idx = $random(seed);
      lsu_access(rand_ram_addr(idx), 1'b0, 4'hf, '0, 1'b0);
    end

    // Partial writes from either side read back through both ports
    for (int i = 0; i < N_PART; i++)
    begin
      idx = $random(seed);
      if ($random(seed) & 1)
        host_access(1'b1, 4'($random(seed)), idx, $random(seed));
      else
        lsu_access(rand_ram_addr(idx), 1'b1, 4'($random(seed)), $random(seed), 1'b0);
      host_access(1'b0, 4'h0, idx, '0);
      lsu_access(rand_ram_addr(idx), 1'b0, 4'hf, '0, 1'b0);
    end

    // External accesses where reads often hit the last written word
    for (int i = 0; i < N_EXT; i++)
    begin
      we   = $random(seed);
      addr = (!we && ($random(seed) & 1)) ? last_ext : rand_ext_addr();
      last_ext = addr;
      lsu_access(addr, we, 4'($random(seed)), $random(seed), 1'b0);
    end

    // Host strobe colliding with an LSU RAM request
    for (int i = 0; i < N_BLOCK; i++)
    begin
      idx = $random(seed);
      we  = $random(seed);
      lsu_access(rand_ram_addr(idx), we, 4'($random(seed)), $random(seed), 1'b1);
      lsu_access(rand_ram_addr(idx), 1'b0, 4'hf, '0, 1'b0);
    end

    // Alternating external and RAM reads
    for (int i = 0; i < N_ALT; i++)
    begin
      lsu_access(rand_ext_addr(), 1'b0, 4'hf, '0, 1'b0);
      idx = $random(seed);
      lsu_access(rand_ram_addr(idx), 1'b0, 4'hf, '0, 1'b0);
    end

    repeat (4) @(posedge clk);
    assert (exp_rd_q.size() == 0 && host_exp_q.size() == 0)
    else
    begin
      errors++;
      $display("Error: responses still outstanding at the end of the run");
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
mem_region_pkg.sv
mem_region_decoder.sv
ram_port_mux.sv
sp_data_ram.sv
core_mem_region.sv
core_mem_region_sva.sv
tb_core_mem_region.sv
